// File: common/obi_xbar_pkg.sv
package obi_xbar_pkg;

  // ----------------------------------------------------------------------
  // Bus geometry
  // ----------------------------------------------------------------------
  // Masters sharing the single slave
  localparam int NumMasters = 5;

  // OBI address and data widths
  localparam int AddrWidth = 32;
  localparam int DataWidth = 32;
  // One enable per data byte
  localparam int BeWidth = DataWidth / 8;

  // Request word layout, msb first: we, be, addr, wdata
  localparam int ReqWordWidth = 1 + BeWidth + AddrWidth + DataWidth;

  // Index of a master
  localparam int MasterIdWidth = $clog2(NumMasters);

  // ----------------------------------------------------------------------
  // Crossbar and slave sizing
  // ----------------------------------------------------------------------
  // Owner queue depth, i.e. transfers in flight
  localparam int MaxOutstanding = 4;

  // SRAM depth in words
  localparam int MemWords = 256;
  // Slowest slave answer, in cycles after the grant
  localparam int MaxReadLatency = 3;

endpackage

// File: source/obi_rr_arbiter.sv
module obi_rr_arbiter
  import obi_xbar_pkg::*;
(
  input  logic                     clk_i,
  input  logic                     rst_i,
  input  logic [NumMasters-1:0]    req_i,
  input  logic                     advance_i,
  output logic [NumMasters-1:0]    grant_o,
  output logic [MasterIdWidth-1:0] grant_idx_o
);

  // Highest priority master this cycle
  logic [MasterIdWidth-1:0] ptr_q;

  // ----------------------------------------------------------------------
  // Winner search
  // ----------------------------------------------------------------------
  // Scan from the pointer upward and wrap at NumMasters
  always_comb begin
    int  idx;
    logic found;
    grant_o     = '0;
    grant_idx_o = '0;
    found       = 1'b0;
    for (int off = 0; off < NumMasters; off++) begin
      idx = int'(ptr_q) + off;
      if (idx >= NumMasters) begin
        idx = idx - NumMasters;
      end
      // First requester wins, later ones ignored
      if (!found && req_i[idx]) begin
        found        = 1'b1;
        grant_o[idx] = 1'b1;
        grant_idx_o  = MasterIdWidth'(idx);
      end
    end
  end

  // ----------------------------------------------------------------------
  // Priority pointer
  // ----------------------------------------------------------------------
  // Moves only on a completed transfer, to one past the winner
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      ptr_q <= '0;
    end else if (advance_i) begin
      if (int'(grant_idx_o) == NumMasters - 1) begin
        ptr_q <= '0;
      end else begin
        ptr_q <= grant_idx_o + 1'b1;
      end
    end
  end

endmodule

// File: xbar/obi_xbar_varlat.sv
module obi_xbar_varlat
  import obi_xbar_pkg::*;
(
  input  logic                                   clk_i,
  input  logic                                   rst_i,

  // Master side, one lane per master
  input  logic [NumMasters-1:0]                  req_i,
  input  logic [NumMasters-1:0][ReqWordWidth-1:0] req_word_i,
  output logic [NumMasters-1:0]                  gnt_o,
  output logic [NumMasters-1:0]                  rvalid_o,
  output logic [NumMasters-1:0][DataWidth-1:0]   rdata_o,

  // Slave side
  output logic                                   slv_req_o,
  output logic [ReqWordWidth-1:0]                slv_req_word_o,
  input  logic                                   slv_gnt_i,
  input  logic                                   slv_rvalid_i,
  input  logic [DataWidth-1:0]                   slv_rdata_i
);

  // Arbiter outputs
  logic [NumMasters-1:0]    win_onehot;
  logic [MasterIdWidth-1:0] win_idx;

  // Owner queue, one entry per outstanding transfer
  logic [MasterIdWidth-1:0]              owner_q [MaxOutstanding];
  logic [$clog2(MaxOutstanding)-1:0]     wr_ptr_q;
  logic [$clog2(MaxOutstanding)-1:0]     rd_ptr_q;
  logic [$clog2(MaxOutstanding+1)-1:0]   count_q;
  logic                                  full;
  logic                                  push;
  logic                                  pop;
  logic [MasterIdWidth-1:0]              owner_head;

  // ----------------------------------------------------------------------
  // Request path
  // ----------------------------------------------------------------------
  obi_rr_arbiter u_arbiter (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .req_i      (req_i),
    .advance_i  (push),
    .grant_o    (win_onehot),
    .grant_idx_o(win_idx)
  );

  // No new transfer while every owner slot is taken
  assign full           = (int'(count_q) == MaxOutstanding);
  assign slv_req_o      = (|req_i) && !full;
  assign slv_req_word_o = req_word_i[win_idx];

  // Slave grant goes back to the winner alone, same cycle
  assign gnt_o = win_onehot & {NumMasters{slv_gnt_i && !full}};

  // Transfer on slave side, response retires the oldest entry
  assign push = slv_req_o && slv_gnt_i;
  assign pop  = slv_rvalid_i;

  // ----------------------------------------------------------------------
  // Owner queue
  // ----------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (push) begin
      owner_q[wr_ptr_q] <= win_idx;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        if (int'(wr_ptr_q) == MaxOutstanding - 1) begin
          wr_ptr_q <= '0;
        end else begin
          wr_ptr_q <= wr_ptr_q + 1'b1;
        end
      end
      if (pop) begin
        if (int'(rd_ptr_q) == MaxOutstanding - 1) begin
          rd_ptr_q <= '0;
        end else begin
          rd_ptr_q <= rd_ptr_q + 1'b1;
        end
      end
      // Occupancy, push and pop may coincide
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // ----------------------------------------------------------------------
  // Response steering
  // ----------------------------------------------------------------------
  // Slave answers in order, so the head names the owner
  assign owner_head = owner_q[rd_ptr_q];

  for (genvar k = 0; k < NumMasters; k++) begin : g_rsp
    assign rvalid_o[k] = slv_rvalid_i && (owner_head == MasterIdWidth'(k));
    // Other lanes see zero data
    assign rdata_o[k]  = rvalid_o[k] ? slv_rdata_i : '0;
  end

endmodule

// File: source/obi_sram_slave.sv
module obi_sram_slave
  import obi_xbar_pkg::*;
(
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  logic                 req_i,
  input  logic                 we_i,
  input  logic [BeWidth-1:0]   be_i,
  input  logic [AddrWidth-1:0] addr_i,
  input  logic [DataWidth-1:0] wdata_i,
  output logic                 gnt_o,
  output logic                 rvalid_o,
  output logic [DataWidth-1:0] rdata_o
);

  // Word storage
  logic [DataWidth-1:0] mem_q [MemWords];
  logic [$clog2(MemWords)-1:0] word_idx;
  logic xfer;

  // Stall and latency source
  logic [7:0] lfsr_q;

  // Response pipeline, stage 0 drives the bus
  logic [MaxReadLatency-1:0]                valid_q;
  logic [MaxReadLatency-1:0]                valid_d;
  logic [MaxReadLatency-1:0][DataWidth-1:0] data_q;
  logic [MaxReadLatency-1:0][DataWidth-1:0] data_d;

  // Word index sits right above the byte offset
  assign word_idx = addr_i[$clog2(BeWidth) +: $clog2(MemWords)];

  // Roughly one cycle in four stalls
  assign gnt_o = (lfsr_q[1:0] != 2'b00);
  assign xfer  = req_i && gnt_o;

  // 8 bit Fibonacci LFSR, taps 8 6 5 4
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      lfsr_q <= 8'h5a;
    end else begin
      lfsr_q <= {lfsr_q[6:0], lfsr_q[7] ^ lfsr_q[5] ^ lfsr_q[4] ^ lfsr_q[3]};
    end
  end

  // ----------------------------------------------------------------------
  // Memory array
  // ----------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      for (int w = 0; w < MemWords; w++) begin
        mem_q[w] <= '0;
      end
    end else if (xfer && we_i) begin
      // Byte lanes merged individually
      for (int b = 0; b < BeWidth; b++) begin
        if (be_i[b]) begin
          mem_q[word_idx][8*b +: 8] <= wdata_i[8*b +: 8];
        end
      end
    end
  end

  // ----------------------------------------------------------------------
  // In-order response pipeline
  // ----------------------------------------------------------------------
  always_comb begin
    int lat;
    int last;
    valid_d = '0;
    data_d  = data_q;
    last    = -1;
    // Shift one stage toward the output
    for (int s = 0; s < MaxReadLatency - 1; s++) begin
      valid_d[s] = valid_q[s+1];
      data_d[s]  = data_q[s+1];
      if (valid_q[s+1]) begin
        last = s;
      end
    end
    // Drawn latency, stage s answers s+1 cycles after grant
    lat = int'(lfsr_q[5:4]);
    if (lat >= MaxReadLatency) begin
      lat = lat - MaxReadLatency;
    end
    // Never overtake an older response
    if (lat <= last) begin
      lat = last + 1;
    end
    if (xfer) begin
      valid_d[lat] = 1'b1;
      // Writes answer with zero data
      data_d[lat]  = we_i ? '0 : mem_q[word_idx];
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      valid_q <= '0;
    end else begin
      valid_q <= valid_d;
    end
  end

  // Payload only
  always_ff @(posedge clk_i) begin
    data_q <= data_d;
  end

  assign rvalid_o = valid_q[0];
  assign rdata_o  = data_q[0];

endmodule

// File: source/obi_xbar_sys.sv
module obi_xbar_sys
  import obi_xbar_pkg::*;
(
  input  logic                                 clk_i,
  input  logic                                 rst_i,

  // Master request fields
  input  logic [NumMasters-1:0]                req_i,
  input  logic [NumMasters-1:0]                we_i,
  input  logic [NumMasters-1:0][BeWidth-1:0]   be_i,
  input  logic [NumMasters-1:0][AddrWidth-1:0] addr_i,
  input  logic [NumMasters-1:0][DataWidth-1:0] wdata_i,

  // Master response fields
  output logic [NumMasters-1:0]                gnt_o,
  output logic [NumMasters-1:0]                rvalid_o,
  output logic [NumMasters-1:0][DataWidth-1:0] rdata_o
);

  // Packed request words, one per master
  logic [NumMasters-1:0][ReqWordWidth-1:0] req_word;

  // Crossbar to slave
  logic                    slv_req;
  logic [ReqWordWidth-1:0] slv_req_word;
  logic                    slv_gnt;
  logic                    slv_rvalid;
  logic [DataWidth-1:0]    slv_rdata;

  // Slave fields unpacked from the forwarded word
  logic                    slv_we;
  logic [BeWidth-1:0]      slv_be;
  logic [AddrWidth-1:0]    slv_addr;
  logic [DataWidth-1:0]    slv_wdata;

  // ----------------------------------------------------------------------
  // Field packing
  // ----------------------------------------------------------------------
  // Layout: we, be, addr, wdata from msb down
  for (genvar k = 0; k < NumMasters; k++) begin : g_pack
    assign req_word[k] = {we_i[k], be_i[k], addr_i[k], wdata_i[k]};
  end

  assign {slv_we, slv_be, slv_addr, slv_wdata} = slv_req_word;

  // ----------------------------------------------------------------------
  // Crossbar and slave
  // ----------------------------------------------------------------------
  obi_xbar_varlat u_xbar (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .req_i         (req_i),
    .req_word_i    (req_word),
    .gnt_o         (gnt_o),
    .rvalid_o      (rvalid_o),
    .rdata_o       (rdata_o),
    .slv_req_o     (slv_req),
    .slv_req_word_o(slv_req_word),
    .slv_gnt_i     (slv_gnt),
    .slv_rvalid_i  (slv_rvalid),
    .slv_rdata_i   (slv_rdata)
  );

  obi_sram_slave u_sram (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .req_i   (slv_req),
    .we_i    (slv_we),
    .be_i    (slv_be),
    .addr_i  (slv_addr),
    .wdata_i (slv_wdata),
    .gnt_o   (slv_gnt),
    .rvalid_o(slv_rvalid),
    .rdata_o (slv_rdata)
  );

endmodule

// File: testbench/obi_xbar_chk.sv
module obi_xbar_chk
  import obi_xbar_pkg::*;
(
  input logic                  clk_i,
  input logic                  rst_i,
  input logic [NumMasters-1:0] req_i,
  input logic [NumMasters-1:0] gnt_o,
  input logic [NumMasters-1:0] rvalid_o
);

  timeunit 1ns;
  timeprecision 1ps;

  // Transfers per master still waiting for rvalid
  int pending [NumMasters];
  // Masters granted while master k keeps waiting
  logic [NumMasters-1:0] seen_q [NumMasters];
  // Count of failed assertions
  int fail_count = 0;

  always_ff @(posedge clk_i) begin
    for (int k = 0; k < NumMasters; k++) begin
      if (rst_i) begin
        pending[k] <= 0;
        seen_q[k]  <= '0;
      end else begin
        pending[k] <= pending[k] + int'(req_i[k] && gnt_o[k]) - int'(rvalid_o[k]);
        // Cleared once k is granted or drops its request
        seen_q[k]  <= (req_i[k] && !gnt_o[k]) ? (seen_q[k] | gnt_o) : '0;
      end
    end
  end

  // ----------------------------------------------------------------------
  // Properties
  // ----------------------------------------------------------------------
  a_reset_quiet: assert property (@(posedge clk_i)
    $past(rst_i) && rst_i |-> (gnt_o == '0) && (rvalid_o == '0))
    else begin
      $error("gnt or rvalid active while in reset");
      fail_count++;
    end

  a_one_gnt: assert property (@(posedge clk_i) disable iff (rst_i) $onehot0(gnt_o))
    else begin
      $error("several masters granted in one cycle");
      fail_count++;
    end

  for (genvar k = 0; k < NumMasters; k++) begin : g_master
    a_rvalid_owned: assert property (@(posedge clk_i) disable iff (rst_i)
      rvalid_o[k] |-> pending[k] > 0)
      else begin
        $error("rvalid to master %0d without an outstanding transfer", k);
        fail_count++;
      end

    // Nobody gets a second grant ahead of a waiting master
    a_fair: assert property (@(posedge clk_i) disable iff (rst_i)
      (req_i[k] && !gnt_o[k]) |-> (seen_q[k] & gnt_o) == '0)
      else begin
        $error("master %0d passed over twice by the same master", k);
        fail_count++;
      end
  end

endmodule

// File: testbench/tb_obi_xbar.sv
module tb_obi_xbar
  import obi_xbar_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  logic                                 clk;
  logic                                 rst;
  logic [NumMasters-1:0]                req;
  logic [NumMasters-1:0]                we;
  logic [NumMasters-1:0][BeWidth-1:0]   be;
  logic [NumMasters-1:0][AddrWidth-1:0] addr;
  logic [NumMasters-1:0][DataWidth-1:0] wdata;
  logic [NumMasters-1:0]                gnt;
  logic [NumMasters-1:0]                rvalid;
  logic [NumMasters-1:0][DataWidth-1:0] rdata;
  // Drivers and collectors start here
  logic                                 run_go;

  // Trace entries in file order
  string                t_name[$];
  int                   t_master[$];
  logic                 t_we[$];
  logic [BeWidth-1:0]   t_be[$];
  logic [AddrWidth-1:0] t_addr[$];
  logic [DataWidth-1:0] t_wdata[$];
  logic [DataWidth-1:0] t_exp[$];
  int                   t_gap[$];
  int                   exp_count [NumMasters];
  int                   rsp_count [NumMasters];

  obi_xbar_sys DUT (
    .clk_i   (clk),
    .rst_i   (rst),
    .req_i   (req),
    .we_i    (we),
    .be_i    (be),
    .addr_i  (addr),
    .wdata_i (wdata),
    .gnt_o   (gnt),
    .rvalid_o(rvalid),
    .rdata_o (rdata)
  );

  bind obi_xbar_sys obi_xbar_chk u_chk (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .req_i   (req_i),
    .gnt_o   (gnt_o),
    .rvalid_o(rvalid_o)
  );

  // ----------------------------------------------------------------------
  // Helpers
  // ----------------------------------------------------------------------
  task automatic stop_run(input string why);
    $display("%s", why);
    $display(">>> FAIL");
    $fatal(1, "run aborted");
  endtask

  task automatic check_value(input string name, input logic [DataWidth-1:0] exp_val,
                             input logic [DataWidth-1:0] act_val);
    if (act_val !== exp_val) begin
      stop_run($sformatf("mismatch %s expected %h actual %h", name, exp_val, act_val));
    end
  endtask

  // Next trace entry of master k starting at index from
  // Returns -1 once master k has no entries left
  function automatic int next_entry(input int k, input int from);
    int found;
    found = -1;
    for (int i = from; i < t_master.size(); i++) begin
      if (found < 0 && t_master[i] == k) begin
        found = i;
      end
    end
    return found;
  endfunction

  function automatic bit all_drained();
    bit done;
    done = 1'b1;
    for (int k = 0; k < NumMasters; k++) begin
      if (rsp_count[k] < exp_count[k]) begin
        done = 1'b0;
      end
    end
    return done;
  endfunction

  task automatic load_trace();
    int                   fd;
    int                   n;
    int                   m;
    string                line;
    string                name;
    logic                 w;
    logic [BeWidth-1:0]   b;
    logic [AddrWidth-1:0] a;
    logic [DataWidth-1:0] d;
    logic [DataWidth-1:0] e;
    fd = $fopen("testbench/obi_xbar_trace.txt", "r");
    if (fd == 0) begin
      stop_run("cannot open trace file testbench/obi_xbar_trace.txt");
    end
    while ($fgets(line, fd) != 0) begin
      // Comment or blank line
      if (line.len() < 2 || line.getc(0) == "#") begin
        continue;
      end
      n = $sscanf(line, "%s %d %h %h %h %h %h", name, m, w, b, a, d, e);
      if (n != 7 || m < 0 || m >= NumMasters) begin
        stop_run({"malformed trace line: ", line});
      end
      t_name.push_back(name);
      t_master.push_back(m);
      t_we.push_back(w);
      t_be.push_back(b);
      t_addr.push_back(a);
      t_wdata.push_back(d);
      t_exp.push_back(e);
      // Idle cycles before this request
      t_gap.push_back(int'($urandom % 4));
      exp_count[m]++;
    end
    $fclose(fd);
  endtask

  // ----------------------------------------------------------------------
  // Clock, reset and run control
  // ----------------------------------------------------------------------
  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  initial begin
    rst    = 1'b1;
    req    = '0;
    we     = '0;
    be     = '0;
    addr   = '0;
    wdata  = '0;
    run_go = 1'b0;
    for (int k = 0; k < NumMasters; k++) begin
      exp_count[k] = 0;
      rsp_count[k] = 0;
    end
    void'($urandom(33));
    load_trace();
    repeat (2) @(posedge clk);
    check_value("reset_gnt", DataWidth'(gnt), '0);
    check_value("reset_rvalid", DataWidth'(rvalid), '0);
    @(negedge clk);
    rst    = 1'b0;
    run_go = 1'b1;
    while (!all_drained()) begin
      @(posedge clk);
    end
    // Extra responses would land in this quiet tail
    repeat (4 * MaxReadLatency) @(posedge clk);
    for (int k = 0; k < NumMasters; k++) begin
      check_value($sformatf("resp_count_m%0d", k), exp_count[k], rsp_count[k]);
    end
    $display(">>> PASS");
    $finish;
  end

  // Forty cycles per transaction is far beyond the worst case
  initial begin
    wait (run_go);
    repeat (t_name.size() * 40) @(posedge clk);
    stop_run($sformatf("timeout, responses never arrived after %0d cycles",
                       t_name.size() * 40));
  end

  // Any failed assertion in the bound checker ends the run
  initial begin
    wait (DUT.u_chk.fail_count != 0);
    stop_run("an assertion in the bound checker failed");
  end

  // ----------------------------------------------------------------------
  // Per master driver and collector
  // ----------------------------------------------------------------------
  for (genvar k = 0; k < NumMasters; k++) begin : g_master
    initial begin
      int idx;
      wait (run_go);
      @(negedge clk);
      idx = next_entry(k, 0);
      while (idx >= 0) begin
        repeat (t_gap[idx]) @(negedge clk);
        req[k]   = 1'b1;
        we[k]    = t_we[idx];
        be[k]    = t_be[idx];
        addr[k]  = t_addr[idx];
        wdata[k] = t_wdata[idx];
        // Fields held until the grant edge
        do begin
          @(posedge clk);
        end while (!gnt[k]);
        @(negedge clk);
        req[k] = 1'b0;
        idx = next_entry(k, idx + 1);
      end
    end

    initial begin
      int idx;
      wait (run_go);
      idx = next_entry(k, 0);
      forever begin
        @(posedge clk);
        if (rvalid[k]) begin
          rsp_count[k]++;
          // Responses beyond the trace only show up in the final count
          if (idx >= 0) begin
            check_value(t_name[idx], t_exp[idx], rdata[k]);
            idx = next_entry(k, idx + 1);
          end
        end
      end
    end
  end

endmodule

// File: build.f
common/obi_xbar_pkg.sv
source/obi_rr_arbiter.sv
xbar/obi_xbar_varlat.sv
source/obi_sram_slave.sv
source/obi_xbar_sys.sv
testbench/obi_xbar_chk.sv
testbench/tb_obi_xbar.sv

// File: testbench/obi_xbar_trace.txt
# columns: name master we be addr wdata exp_rdata, all hex except name and master
# each master stays inside its own 64 byte region, writes expect zero rdata
be_full_wr   0 1 f 00000000 11223344 00000000
m1_wr_a      1 1 f 00000040 a1a1a1a1 00000000
be_part_wr   0 1 5 00000000 aabbccdd 00000000
m2_wr_hi     2 1 c 00000080 12345678 00000000
m3_wr_a      3 1 f 000000c0 cafef00d 00000000
m4_wr_top    4 1 8 00000100 77000000 00000000
be_merge_rd  0 0 0 00000000 00000000 11bb33dd
m1_wr_lo     1 1 3 00000044 0000beef 00000000
m2_rd_hi     2 0 0 00000080 00000000 12340000
m3_wr_b1     3 1 2 000000c0 00005500 00000000
m4_wr_low    4 1 1 00000104 00000066 00000000
untouched_rd 0 0 0 00000004 00000000 00000000
m1_rd_a      1 0 0 00000040 00000000 a1a1a1a1
m2_wr_lo     2 1 3 00000080 9abcdef0 00000000
m3_rd_a      3 0 0 000000c0 00000000 cafe550d
m4_rd_top    4 0 0 00000100 00000000 77000000
m1_rd_lo     1 0 0 00000044 00000000 0000beef
m2_rd_merge  2 0 0 00000080 00000000 1234def0
m3_rd_zero   3 0 0 000000c8 00000000 00000000
m4_rd_low    4 0 0 00000104 00000000 00000066
m4_wr_full   4 1 f 00000100 01020304 00000000
m4_rd_full   4 0 0 00000100 00000000 01020304
